// ==== flist.f ====
+incdir+hdl
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/writebackStage.sv
hdl/cpuCore.sv
tb/memoryModel.sv
tb/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpuPkg.sv
      - hdl/fetchStage.sv
      - hdl/instrDecoder.sv
      - hdl/registerFile.sv
      - hdl/decodeStage.sv
      - hdl/executeStage.sv
      - hdl/writebackStage.sv
      - hdl/cpuCore.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/memoryModel.sv
      - tb/cpuTb.sv

// ==== tb/cpuTb.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpuTb;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int QUIET_CYCLES = 50;
    localparam int IMEM_WORDS = 64;

    typedef struct packed {
        cpuPkg::word_t pc;
        cpuPkg::regAddr_t num;
        cpuPkg::word_t data;
    } regWrite_t;

    logic clk;
    logic reset;
    cpuPkg::instReq_t instReq;
    cpuPkg::instResp_t instResp;
    cpuPkg::dataReq_t dataReq;
    cpuPkg::dataResp_t dataResp;
    cpuPkg::wbTrace_t trace;

    cpuPkg::word_t progWords [$];
    regWrite_t expWrites [$];
    cpuPkg::word_t refRegs [32];      // Architectural registers per MIPS rules

    cpuCore dut (
        .clk(clk),
        .reset(reset),
        .instReq(instReq),
        .instResp(instResp),
        .dataReq(dataReq),
        .dataResp(dataResp),
        .trace(trace)
    );

    memoryModel mem (
        .clk(clk),
        .reset(reset),
        .instReq(instReq),
        .instResp(instResp),
        .dataReq(dataReq),
        .dataResp(dataResp)
    );

    always #4 clk = ~clk;

    function automatic cpuPkg::word_t encodeR(input logic [5:0] fn, input int rs,
                                              input int rt, input int rd);
        return {`OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic cpuPkg::word_t encodeI(input logic [5:0] op, input int rs,
                                              input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // Jump to a program index
    function automatic cpuPkg::word_t encodeJ(input int index);
        cpuPkg::word_t dest;
        dest = `RESET_PC + 32'(index * 4);
        return {`OP_J, dest[27:2]};
    endfunction

    task automatic stopOnError();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout at %0t after %0d cycles waiting for %s", $time, TIMEOUT_CYCLES, what);
        stopOnError();
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] wanted);
        if (actual !== wanted) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, wanted);
            stopOnError();
        end
    endtask

    // Index is the position of the writing instruction in the program
    task automatic recordWrite(input int index, input int num, input cpuPkg::word_t value);
        regWrite_t w;
        w.pc = `RESET_PC + 32'(index * 4);
        w.num = 5'(num);
        w.data = value;
        refRegs[num] = value;
        expWrites.push_back(w);
    endtask

    task automatic buildProgram();
        progWords.push_back(encodeI(`OP_LUI, 0, 1, 16'h1234));
        progWords.push_back(encodeI(`OP_ORI, 1, 1, 16'h5678));
        progWords.push_back(encodeI(`OP_ADDIU, 1, 2, 16'hFFF8));
        progWords.push_back(encodeR(`FN_ADDU, 2, 1, 3));          // E and M forwarding
        progWords.push_back(encodeR(`FN_SUBU, 3, 1, 4));
        progWords.push_back(encodeR(`FN_AND, 4, 3, 5));
        progWords.push_back(encodeR(`FN_OR, 5, 2, 6));
        progWords.push_back(encodeR(`FN_SLT, 2, 3, 7));
        progWords.push_back(encodeI(`OP_ADDIU, 0, 8, 16'hFFFF));
        progWords.push_back(encodeR(`FN_SLT, 8, 0, 9));
        progWords.push_back(encodeI(`OP_ORI, 0, 10, 16'h0040));
        progWords.push_back(encodeI(`OP_SW, 10, 6, 16'h0004));
        progWords.push_back(encodeI(`OP_LW, 10, 11, 16'h0004));
        progWords.push_back(encodeR(`FN_ADDU, 11, 1, 12));        // Load-use stall
        progWords.push_back(encodeI(`OP_SW, 10, 12, 16'h0000));
        progWords.push_back(encodeI(`OP_LW, 10, 13, 16'h0000));
        progWords.push_back(encodeR(`FN_SUBU, 13, 11, 14));
        progWords.push_back(encodeI(`OP_BEQ, 11, 6, 16'd2));      // Taken to index 20
        progWords.push_back(encodeI(`OP_ADDIU, 0, 15, 16'h0011));
        progWords.push_back(encodeI(`OP_ADDIU, 0, 16, 16'h0099)); // Skipped
        progWords.push_back(encodeI(`OP_BNE, 15, 15, 16'd9));     // Never taken
        progWords.push_back(encodeI(`OP_ADDIU, 15, 17, 16'h0001));
        progWords.push_back(encodeI(`OP_ADDIU, 0, 18, 16'h0022));
        progWords.push_back(encodeJ(26));
        progWords.push_back(encodeI(`OP_ORI, 18, 19, 16'h0100));
        progWords.push_back(encodeI(`OP_ADDIU, 0, 20, 16'h0055)); // Skipped
        progWords.push_back(encodeI(`OP_ADDIU, 0, 0, 16'h0005));
        progWords.push_back(encodeR(`FN_ADDU, 1, 1, 0));
        progWords.push_back(encodeR(`FN_ADDU, 0, 1, 21));
        progWords.push_back(encodeJ(29));                          // Park here
        progWords.push_back(32'h00000000);
    endtask

    task automatic buildExpected();
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        recordWrite(0, 1, 32'h12340000);
        recordWrite(1, 1, refRegs[1] | 32'h00005678);
        recordWrite(2, 2, refRegs[1] + 32'hFFFFFFF8);
        recordWrite(3, 3, refRegs[2] + refRegs[1]);
        recordWrite(4, 4, refRegs[3] - refRegs[1]);
        recordWrite(5, 5, refRegs[4] & refRegs[3]);
        recordWrite(6, 6, refRegs[5] | refRegs[2]);
        recordWrite(7, 7, ($signed(refRegs[2]) < $signed(refRegs[3])) ? 32'd1 : 32'd0);
        recordWrite(8, 8, 32'hFFFFFFFF);
        recordWrite(9, 9, ($signed(refRegs[8]) < $signed(refRegs[0])) ? 32'd1 : 32'd0);
        recordWrite(10, 10, 32'h00000040);
        recordWrite(12, 11, refRegs[6]);                  // Stored then loaded back
        recordWrite(13, 12, refRegs[11] + refRegs[1]);
        recordWrite(15, 13, refRegs[12]);
        recordWrite(16, 14, refRegs[13] - refRegs[11]);
        recordWrite(18, 15, 32'h00000011);
        recordWrite(21, 17, refRegs[15] + 32'd1);
        recordWrite(22, 18, 32'h00000022);
        recordWrite(24, 19, refRegs[18] | 32'h00000100);
        recordWrite(28, 21, refRegs[0] + refRegs[1]);     // r0 still reads zero
    endtask

    task automatic waitFirstFetch();
        int cycles;
        cycles = 0;
        while (!instReq.readEn) begin
            if (cycles == TIMEOUT_CYCLES) begin
                reportTimeout("the first instruction fetch");
            end
            @(negedge clk);
            compareValue("trace.wen", trace.wen, 0);
            cycles++;
        end
        compareValue("instReq.addr", instReq.addr, `RESET_PC);
    endtask

    task automatic waitTraceWrite(input int index);
        int cycles;
        cycles = 0;
        while (!trace.wen) begin
            if (cycles == TIMEOUT_CYCLES) begin
                reportTimeout($sformatf("register write %0d", index));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        buildProgram();
        buildExpected();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            mem.loadInstr(i, (i < progWords.size()) ? progWords[i] : 32'h0);
        end
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            compareValue("trace.wen", trace.wen, 0);
            compareValue("instReq.readEn", instReq.readEn, 0);
            compareValue("dataReq.read", dataReq.read, 0);
            compareValue("dataReq.write", dataReq.write, 0);
        end
        reset <= 1'b0;
        waitFirstFetch();
        for (int i = 0; i < expWrites.size(); i++) begin
            waitTraceWrite(i);
            compareValue("trace.pc", trace.pc, expWrites[i].pc);
            compareValue("trace.wnum", trace.wnum, expWrites[i].num);
            compareValue("trace.wdata", trace.wdata, expWrites[i].data);
            @(negedge clk);
        end
        // Parked in the final loop with no further writes
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            compareValue("trace.wen", trace.wen, 0);
            @(negedge clk);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== tb/memoryModel.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module memoryModel (
    input  logic clk,
    input  logic reset,
    input  cpuPkg::instReq_t instReq,
    output cpuPkg::instResp_t instResp,
    input  cpuPkg::dataReq_t dataReq,
    output cpuPkg::dataResp_t dataResp
);

    localparam logic [31:0] LFSR_SEED = 32'h4555cd7c;

    cpuPkg::word_t imem [64];
    cpuPkg::word_t dmem [64];
    logic [31:0] lfsr;
    logic instBusy;
    logic dataBusy;
    int instWait;
    int dataWait;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    function automatic cpuPkg::word_t fillWord(input cpuPkg::word_t addr);
        return addr ^ 32'hA5A55A5A;
    endfunction

    // Only enabled byte lanes change
    function automatic cpuPkg::word_t mergeBytes(input cpuPkg::word_t old,
                                                 input cpuPkg::word_t wdata,
                                                 input logic [3:0] en);
        cpuPkg::word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (en[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Latency of 0 to 3 cycles from one LFSR step per bit
    task automatic drawLatency(output int lat);
        lat = 0;
        for (int i = 0; i < 2; i++) begin
            lat = lat | (int'(lfsr[0]) << i);
            lfsr = lfsrStep(lfsr);
        end
    endtask

    task automatic loadInstr(input int index, input cpuPkg::word_t value);
        imem[index] = value;
    endtask

    function automatic cpuPkg::word_t readInstr(input cpuPkg::word_t addr);
        cpuPkg::word_t offset;
        offset = addr - `RESET_PC;
        return (offset < 32'd256) ? imem[offset[7:2]] : 32'h0;   // Outside reads as nop
    endfunction

    initial begin
        instResp = '0;
        dataResp = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(32'(i * 4));
        end
    end

    // A request still present after a response is a new one
    always @(negedge clk) begin
        if (reset) begin
            lfsr = LFSR_SEED;
            instBusy = 1'b0;
            dataBusy = 1'b0;
            instResp <= '0;
            dataResp <= '0;
        end else begin
            instResp.valid <= 1'b0;
            if (!instReq.readEn) begin
                instBusy = 1'b0;
            end else begin
                if (instBusy) begin
                    instWait = instWait - 1;
                end else begin
                    drawLatency(instWait);
                    instBusy = 1'b1;
                end
                if (instWait == 0) begin
                    instBusy = 1'b0;
                    instResp <= {1'b1, readInstr(instReq.addr)};
                end
            end
            dataResp.valid <= 1'b0;
            if (!(dataReq.read || dataReq.write)) begin
                dataBusy = 1'b0;
            end else begin
                if (dataBusy) begin
                    dataWait = dataWait - 1;
                end else begin
                    drawLatency(dataWait);
                    dataBusy = 1'b1;
                end
                if (dataWait == 0) begin
                    dataBusy = 1'b0;
                    dataResp <= {1'b1, dmem[dataReq.addr[7:2]]};
                    if (dataReq.write) begin
                        dmem[dataReq.addr[7:2]] = mergeBytes(dmem[dataReq.addr[7:2]],
                                                             dataReq.wdata,
                                                             dataReq.byteEn);
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore (
    input  logic clk,
    input  logic reset,
    output cpuPkg::instReq_t instReq,
    input  cpuPkg::instResp_t instResp,
    output cpuPkg::dataReq_t dataReq,
    input  cpuPkg::dataResp_t dataResp,
    output cpuPkg::wbTrace_t trace
);

    cpuPkg::word_t fetchInstr;
    cpuPkg::word_t fetchPc;
    logic fetchBubble;
    logic decodeStall;
    logic redirect;
    cpuPkg::word_t target;
    cpuPkg::ctrl_t execCtrl;
    cpuPkg::word_t execA;
    cpuPkg::word_t execB;
    cpuPkg::word_t execPc;
    logic execStall;
    cpuPkg::fwdSrc_t fwdE;
    cpuPkg::fwdSrc_t fwdM;
    cpuPkg::regAddr_t memDest;
    cpuPkg::word_t memResult;
    cpuPkg::word_t memPc;
    logic memValid;
    cpuPkg::regAddr_t writeAddr;
    cpuPkg::word_t writeData;

    fetchStage fetch (
        .clk(clk),
        .reset(reset),
        .stall(decodeStall),
        .redirect(redirect),
        .target(target),
        .instReq(instReq),
        .instResp(instResp),
        .instr(fetchInstr),
        .pc(fetchPc),
        .bubble(fetchBubble)
    );

    decodeStage decode (
        .clk(clk),
        .reset(reset),
        .instr(fetchInstr),
        .pc(fetchPc),
        .fetchBubble(fetchBubble),
        .execStall(execStall),
        .fwdE(fwdE),
        .fwdM(fwdM),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .redirect(redirect),
        .target(target),
        .stall(decodeStall),
        .execCtrl(execCtrl),
        .execA(execA),
        .execB(execB),
        .execPc(execPc)
    );

    executeStage execute (
        .clk(clk),
        .reset(reset),
        .ctrl(execCtrl),
        .a(execA),
        .b(execB),
        .pc(execPc),
        .dataReq(dataReq),
        .dataResp(dataResp),
        .stall(execStall),
        .fwdE(fwdE),
        .memDest(memDest),
        .memResult(memResult),
        .memPc(memPc),
        .memValid(memValid)
    );

    writebackStage writeback (
        .dest(memDest),
        .result(memResult),
        .pc(memPc),
        .valid(memValid),
        .fwdM(fwdM),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .trace(trace)
    );

endmodule

// ==== hdl/writebackStage.sv ====
`timescale 1ns/100ps

module writebackStage (
    input  cpuPkg::regAddr_t dest,
    input  cpuPkg::word_t result,
    input  cpuPkg::word_t pc,
    input  logic valid,
    output cpuPkg::fwdSrc_t fwdM,
    output cpuPkg::regAddr_t writeAddr,
    output cpuPkg::word_t writeData
    ,
    output cpuPkg::wbTrace_t trace
);

    assign writeAddr = valid ? dest : '0;   // Register 0 stays a non-write
    assign writeData = result;

    assign fwdM.valid = valid;
    assign fwdM.dest = writeAddr;
    assign fwdM.value = result;

    assign trace.pc = pc;
    assign trace.wen = (writeAddr != '0);
    assign trace.wnum = writeAddr;
    assign trace.wdata = result;

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
    input  logic clk,
    input  logic reset,
    input  cpuPkg::ctrl_t ctrl,
    input  cpuPkg::word_t a,
    input  cpuPkg::word_t b,
    input  cpuPkg::word_t pc,
    output cpuPkg::dataReq_t dataReq,
    input  cpuPkg::dataResp_t dataResp,
    output logic stall,
    output cpuPkg::fwdSrc_t fwdE,
    output cpuPkg::regAddr_t memDest,
    output cpuPkg::word_t memResult,
    output cpuPkg::word_t memPc,
    output logic memValid
);

    cpuPkg::word_t operandB;
    cpuPkg::word_t aluResult;

    assign operandB = ctrl.aluSrcImm ? ctrl.imm : b;

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluSub: aluResult = a - operandB;
            cpuPkg::aluAnd: aluResult = a & operandB;
            cpuPkg::aluOr: aluResult = a | operandB;
            cpuPkg::aluSlt: aluResult = {31'b0, $signed(a) < $signed(operandB)};
            cpuPkg::aluLui: aluResult = {operandB[15:0], 16'h0000};
            default: aluResult = a + operandB;
        endcase
    end

    // Loads and stores take their address from the adder
    assign dataReq.read = ctrl.memLoad;
    assign dataReq.write = ctrl.memStore;
    assign dataReq.addr = aluResult;
    assign dataReq.wdata = b;
    assign dataReq.byteEn = {4{ctrl.memStore}};

    assign stall = (ctrl.memLoad || ctrl.memStore) && !dataResp.valid;

    // Load data is not ready here, so Decode sees valid low for it
    assign fwdE.valid = (ctrl.wbSrc == cpuPkg::wbAlu);
    assign fwdE.dest = (ctrl.wbSrc != cpuPkg::wbNone) ? ctrl.destReg : '0;
    assign fwdE.value = aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            memValid <= 1'b0;
        end else begin
            memValid <= !stall && ctrl.wbSrc != cpuPkg::wbNone;  // Bubble while waiting
        end
    end

    always_ff @(posedge clk) begin
        memDest <= ctrl.destReg;
        memResult <= ctrl.memLoad ? dataResp.rdata : aluResult;
        memPc <= pc;
    end

endmodule

// ==== hdl/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
    input  logic clk,
    input  logic reset,
    input  cpuPkg::word_t instr,
    input  cpuPkg::word_t pc,
    input  logic fetchBubble,
    input  logic execStall,
    input  cpuPkg::fwdSrc_t fwdE,
    input  cpuPkg::fwdSrc_t fwdM,
    input  cpuPkg::regAddr_t writeAddr,
    input  cpuPkg::word_t writeData,
    output logic redirect,
    output cpuPkg::word_t target,
    output logic stall,
    output cpuPkg::ctrl_t execCtrl,
    output cpuPkg::word_t execA,
    output cpuPkg::word_t execB,
    output cpuPkg::word_t execPc
);

    logic dValid;
    cpuPkg::word_t dInstr;
    cpuPkg::word_t dPc;
    cpuPkg::ctrl_t ctrl;
    cpuPkg::word_t rfData1;
    cpuPkg::word_t rfData2;
    cpuPkg::fwdSrc_t srcA;
    cpuPkg::fwdSrc_t srcB;
    cpuPkg::word_t pcPlus4;
    logic loadUse;
    logic taken;

    // Execute wins over Memory; valid low in the result means a load still pending
    function automatic cpuPkg::fwdSrc_t forward(
        input cpuPkg::regAddr_t r,
        input cpuPkg::word_t rfValue,
        input cpuPkg::fwdSrc_t e,
        input cpuPkg::fwdSrc_t m
    );
        cpuPkg::fwdSrc_t res;
        res.valid = 1'b1;
        res.dest = r;
        res.value = rfValue;
        if (r != '0 && e.dest == r) begin
            res.valid = e.valid;
            res.value = e.value;
        end else if (r != '0 && m.dest == r) begin
            res.value = m.value;
        end
        return res;
    endfunction

    instrDecoder decoder (
        .instr(dInstr),
        .ctrl(ctrl)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .readAddr1(ctrl.readReg1),
        .readAddr2(ctrl.readReg2),
        .readData1(rfData1),
        .readData2(rfData2),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

    assign srcA = forward(ctrl.readReg1, rfData1, fwdE, fwdM);
    assign srcB = forward(ctrl.readReg2, rfData2, fwdE, fwdM);
    assign loadUse = dValid && (!srcA.valid || !srcB.valid);
    assign stall = loadUse || execStall;

    always_comb begin
        case (ctrl.branch)
            cpuPkg::brEq: taken = (srcA.value == srcB.value);
            cpuPkg::brNe: taken = (srcA.value != srcB.value);
            default: taken = ctrl.jump;
        endcase
    end

    assign pcPlus4 = dPc + 32'd4;
    assign redirect = dValid && taken && !stall;    // Only once the branch moves on
    assign target = ctrl.jump ? {pcPlus4[31:28], ctrl.jumpIndex, 2'b00}
                              : pcPlus4 + {ctrl.imm[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
            execCtrl <= cpuPkg::ctrlNop;
        end else begin
            if (!stall) begin
                dValid <= !fetchBubble;
            end
            if (!execStall) begin
                execCtrl <= (dValid && !loadUse) ? ctrl : cpuPkg::ctrlNop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dInstr <= instr;
            dPc <= pc;
        end
        if (!execStall) begin
            execA <= srcA.value;
            execB <= srcB.value;
            execPc <= dPc;
        end
    end

endmodule

// ==== hdl/registerFile.sv ====
`timescale 1ns/100ps

module registerFile (
    input  logic clk,
    input  logic reset,
    input  cpuPkg::regAddr_t readAddr1,
    input  cpuPkg::regAddr_t readAddr2,
    output cpuPkg::word_t readData1,
    output cpuPkg::word_t readData2,
    input  cpuPkg::regAddr_t writeAddr,    // Zero means no write
    input  cpuPkg::word_t writeData
);

    cpuPkg::word_t regs [32];

    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module instrDecoder (
    input  cpuPkg::word_t instr,
    output cpuPkg::ctrl_t ctrl
);

    cpuPkg::word_t immSigned;
    cpuPkg::word_t immZero;

    assign immSigned = {{16{instr[15]}}, instr[15:0]};
    assign immZero = {16'h0000, instr[15:0]};

    always_comb begin
        ctrl = cpuPkg::ctrlNop;
        case (instr[31:26])
            `OP_SPECIAL: begin
                ctrl.readReg1 = instr[25:21];
                ctrl.readReg2 = instr[20:16];
                ctrl.destReg = instr[15:11];
                ctrl.wbSrc = cpuPkg::wbAlu;
                case (instr[5:0])
                    `FN_ADDU: ctrl.aluOp = cpuPkg::aluAdd;
                    `FN_SUBU: ctrl.aluOp = cpuPkg::aluSub;
                    `FN_AND: ctrl.aluOp = cpuPkg::aluAnd;
                    `FN_OR: ctrl.aluOp = cpuPkg::aluOr;
                    `FN_SLT: ctrl.aluOp = cpuPkg::aluSlt;
                    default: ctrl = cpuPkg::ctrlNop;
                endcase
            end
            `OP_ADDIU, `OP_ORI, `OP_LUI: begin
                ctrl.readReg1 = instr[25:21];
                ctrl.destReg = instr[20:16];
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSrc = cpuPkg::wbAlu;
                ctrl.imm = immSigned;
                if (instr[31:26] == `OP_ORI) begin
                    ctrl.aluOp = cpuPkg::aluOr;
                    ctrl.imm = immZero;
                end else if (instr[31:26] == `OP_LUI) begin
                    ctrl.readReg1 = '0;     // LUI ignores rs
                    ctrl.aluOp = cpuPkg::aluLui;
                    ctrl.imm = immZero;
                end
            end
            `OP_LW, `OP_SW: begin
                ctrl.readReg1 = instr[25:21];
                ctrl.aluSrcImm = 1'b1;      // ALU forms the address
                ctrl.imm = immSigned;
                if (instr[31:26] == `OP_LW) begin
                    ctrl.destReg = instr[20:16];
                    ctrl.memLoad = 1'b1;
                    ctrl.wbSrc = cpuPkg::wbMem;
                end else begin
                    ctrl.readReg2 = instr[20:16];
                    ctrl.memStore = 1'b1;
                end
            end
            `OP_BEQ, `OP_BNE: begin
                ctrl.readReg1 = instr[25:21];
                ctrl.readReg2 = instr[20:16];
                ctrl.imm = immSigned;
                ctrl.branch = (instr[31:26] == `OP_BEQ) ? cpuPkg::brEq : cpuPkg::brNe;
            end
            `OP_J: begin
                ctrl.jump = 1'b1;
                ctrl.jumpIndex = instr[25:0];
            end
            default: ctrl = cpuPkg::ctrlNop;
        endcase
    end

endmodule

// ==== hdl/fetchStage.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetchStage (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic redirect,
    input  cpuPkg::word_t target,
    output cpuPkg::instReq_t instReq,
    input  cpuPkg::instResp_t instResp,
    output cpuPkg::word_t instr,
    output cpuPkg::word_t pc,
    output logic bubble
);

    logic started;
    logic held;                 // Word arrived while Decode was stalled
    cpuPkg::word_t heldInstr;
    logic pendingRedirect;
    cpuPkg::word_t pendingTarget;
    cpuPkg::word_t pcReg;
    logic complete;

    assign bubble = !(held || instResp.valid);
    assign instr = held ? heldInstr : instResp.rdata;
    assign pc = pcReg;
    assign complete = !bubble && !stall;

    assign instReq.readEn = started && !held;
    assign instReq.addr = pcReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
            held <= 1'b0;
            pendingRedirect <= 1'b0;
            pcReg <= `RESET_PC;
        end else begin
            started <= 1'b1;
            if (complete) begin
                held <= 1'b0;
                pendingRedirect <= 1'b0;
                if (redirect) begin
                    pcReg <= target;
                end else if (pendingRedirect) begin
                    pcReg <= pendingTarget;
                end else begin
                    pcReg <= pcReg + 32'd4;
                end
            end else begin
                if (instResp.valid) begin
                    held <= 1'b1;
                end
                if (redirect) begin
                    pendingRedirect <= 1'b1;    // Delay slot still in flight
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instResp.valid) begin
            heldInstr <= instResp.rdata;
        end
        if (redirect) begin
            pendingTarget <= target;
        end
    end

endmodule

// ==== hdl/cpuPkg.sv ====
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOp_t;
    typedef enum logic [1:0] {wbNone, wbAlu, wbMem} wbSrc_t;
    typedef enum logic [1:0] {brNone, brEq, brNe} branch_t;

    typedef struct packed {
        regAddr_t readReg1;     // Zero when rs is not read
        regAddr_t readReg2;
        regAddr_t destReg;
        aluOp_t aluOp;
        logic aluSrcImm;
        word_t imm;             // Already extended
        logic memLoad;
        logic memStore;
        branch_t branch;
        logic jump;
        logic [25:0] jumpIndex;
        wbSrc_t wbSrc;
    } ctrl_t;

    // All-zero control is a no-op
    localparam ctrl_t ctrlNop = '0;

    typedef struct packed {
        logic readEn;
        word_t addr;
    } instReq_t;

    typedef struct packed {
        logic valid;
        word_t rdata;
    } instResp_t;

    typedef struct packed {
        logic read;
        logic write;
        word_t addr;
        word_t wdata;
        logic [3:0] byteEn;
    } dataReq_t;

    typedef struct packed {
        logic valid;
        word_t rdata;
    } dataResp_t;

    typedef struct packed {
        logic valid;            // Low while the value is still on its way from memory
        regAddr_t dest;
        word_t value;
    } fwdSrc_t;

    typedef struct packed {
        word_t pc;
        logic wen;
        regAddr_t wnum;
        word_t wdata;
    } wbTrace_t;

endpackage

// ==== hdl/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// First fetch address after reset
`define RESET_PC 32'hBFC00000

// Primary opcodes
`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0D
`define OP_LUI     6'h0F
`define OP_LW      6'h23
`define OP_SW      6'h2B

// Function codes under SPECIAL
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2A

`endif
